// ==== fp_mul_pkg.sv ====
`default_nettype none

package fp_mul_pkg;

    // full 24x24 mantissa product
    localparam int prod_w    = 48;
    // 26 fraction bits plus sticky
    localparam int norm_w    = 27;
    // signed, wide enough for both range ends
    localparam int exp_sum_w = 10;

    localparam logic [exp_sum_w-1:0] exp_bias  = 10'd127;
    localparam logic [31:0]          canon_nan = 32'h7fc0_0000;

    typedef struct packed {
        logic        sign;
        logic [7:0]  exp;
        logic [22:0] frac;
    } fp32_fields_t;

    // raw word on the ports, field view for decode and pack
    typedef union packed {
        logic [31:0]  bits;
        fp32_fields_t f;
    } fp32_t;

    typedef enum logic [2:0] {
        rnd_ne = 3'd0,
        rnd_tz = 3'd1,
        rnd_dn = 3'd2,
        rnd_up = 3'd3,
        rnd_mm = 3'd4
    } round_mode_e;

endpackage

`default_nettype wire

// ==== fp_mul_booth.sv ====
`timescale 1ns/10ps
`default_nettype none

module fp_mul_booth import fp_mul_pkg::*; (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        in_valid,
    input  fp32_t                       fp_x,
    input  fp32_t                       fp_y,
    input  round_mode_e                 r_mode,
    output logic                        s1_valid,
    output logic [prod_w-1:0]           frc_z_full,
    output logic                        sign_z,
    output logic signed [exp_sum_w-1:0] exp_sum,
    output logic                        zero_in,
    output logic                        inf_in,
    output logic                        nan_in,
    output round_mode_e                 s1_mode
);

    localparam int booth_groups = 12;

    logic [23:0]          mant_x;
    logic [23:0]          mant_y;
    logic [24:0]          mult_ext;
    logic [prod_w-1:0]    prod_d;
    logic [exp_sum_w-1:0] exp_sum_d;
    logic                 x_zero, x_inf, x_nan;
    logic                 y_zero, y_inf, y_nan;

    always_comb begin
        x_zero = (fp_x.f.exp == 8'h00);
        x_inf  = (fp_x.f.exp == 8'hff) && (fp_x.f.frac == '0);
        x_nan  = (fp_x.f.exp == 8'hff) && (fp_x.f.frac != '0);
        y_zero = (fp_y.f.exp == 8'h00);
        y_inf  = (fp_y.f.exp == 8'hff) && (fp_y.f.frac == '0);
        y_nan  = (fp_y.f.exp == 8'hff) && (fp_y.f.frac != '0);
    end

    assign mant_x   = {1'b1, fp_x.f.frac};
    assign mant_y   = {1'b1, fp_y.f.frac};
    assign mult_ext = {mant_y, 1'b0};

    // radix-4 booth over twelve overlapping triplets of the multiplier
    always_comb begin
        logic [prod_w-1:0] pp;
        prod_d = '0;
        for (int i = 0; i < booth_groups; i++) begin
            case (mult_ext[2*i +: 3])
                3'b001, 3'b010: pp = {24'b0, mant_x};
                3'b011:         pp = {23'b0, mant_x, 1'b0};
                3'b100:         pp = -{23'b0, mant_x, 1'b0};
                3'b101, 3'b110: pp = -{24'b0, mant_x};
                default:        pp = '0;
            endcase
            prod_d = prod_d + (pp << (2 * i));
        end
        // top triplet takes the hidden 1 as a sign and loses x << 24
        prod_d = prod_d + {mant_x, 24'b0};
    end

    assign exp_sum_d = {2'b00, fp_x.f.exp} + {2'b00, fp_y.f.exp} - exp_bias;

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        frc_z_full <= prod_d;
        sign_z     <= fp_x.f.sign ^ fp_y.f.sign;
        exp_sum    <= exp_sum_d;
        zero_in    <= x_zero | y_zero;
        inf_in     <= x_inf | y_inf;
        // zero times infinity is invalid too
        nan_in     <= x_nan | y_nan | (x_zero & y_inf) | (y_zero & x_inf);
        s1_mode    <= r_mode;
    end

endmodule

`default_nettype wire

// ==== fp_mul_norm.sv ====
`timescale 1ns/10ps
`default_nettype none

module fp_mul_norm import fp_mul_pkg::*; (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        s1_valid,
    input  logic [prod_w-1:0]           frc_z_full,
    input  logic                        sign_z,
    input  logic signed [exp_sum_w-1:0] exp_sum,
    input  logic                        zero_in,
    input  logic                        inf_in,
    input  logic                        nan_in,
    input  round_mode_e                 s1_mode,
    output logic                        s2_valid,
    output logic [norm_w-1:0]           frc_z_norm,
    output logic                        norm_n,
    output logic                        s2_sign,
    output logic signed [exp_sum_w-1:0] s2_exp,
    output logic                        s2_zero,
    output logic                        s2_inf,
    output logic                        s2_nan,
    output round_mode_e                 s2_mode
);

    logic                 shift_d;
    logic [norm_w-1:0]    frac_d;

    // product is in [1,4), at most one bit of shift
    assign shift_d = frc_z_full[prod_w-1];
    assign frac_d  = shift_d ? {frc_z_full[47:22], |frc_z_full[21:0]}
                             : {frc_z_full[46:21], |frc_z_full[20:0]};

    always_ff @(posedge clk) begin
        if (reset) begin
            s2_valid <= 1'b0;
        end else begin
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        frc_z_norm <= frac_d;
        norm_n     <= shift_d;
        s2_exp     <= exp_sum + $signed({9'b0, shift_d});
        s2_sign    <= sign_z;
        s2_zero    <= zero_in;
        s2_inf     <= inf_in;
        s2_nan     <= nan_in;
        s2_mode    <= s1_mode;
    end

endmodule

`default_nettype wire

// ==== fp_mul_round.sv ====
`timescale 1ns/10ps
`default_nettype none

module fp_mul_round import fp_mul_pkg::*; (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        s2_valid,
    input  logic [norm_w-1:0]           frc_z_norm,
    input  logic                        s2_sign,
    input  logic signed [exp_sum_w-1:0] s2_exp,
    input  logic                        s2_zero,
    input  logic                        s2_inf,
    input  logic                        s2_nan,
    input  round_mode_e                 s2_mode,
    output logic                        out_valid,
    output fp32_t                       fp_z,
    output logic                        norm_r,
    output logic                        ovrf,
    output logic                        udrf,
    output logic                        zer,
    output logic                        inf,
    output logic                        nan
);

    logic [22:0]                 mant;
    logic                        guard;
    logic                        sticky;
    logic                        inc;
    logic [23:0]                 mant_sum;
    logic                        carry;
    logic signed [exp_sum_w-1:0] exp_r;
    fp32_t                       z_d;
    logic                        ovrf_d, udrf_d, zer_d, inf_d, nan_d;

    assign mant   = frc_z_norm[25:3];
    assign guard  = frc_z_norm[2];
    assign sticky = |frc_z_norm[1:0];

    always_comb begin
        case (s2_mode)
            rnd_ne:  inc = guard & (sticky | mant[0]);
            rnd_dn:  inc = s2_sign & (guard | sticky);
            rnd_up:  inc = ~s2_sign & (guard | sticky);
            rnd_mm:  inc = guard;
            // rnd_tz and unknown codes truncate
            default: inc = 1'b0;
        endcase
    end

    assign mant_sum = {1'b0, mant} + {23'b0, inc};
    assign carry    = mant_sum[23];
    assign exp_r    = s2_exp + $signed({9'b0, carry});

    always_comb begin
        z_d.f.sign = s2_sign;
        z_d.f.exp  = exp_r[7:0];
        // a rounding carry leaves all zeros here
        z_d.f.frac = mant_sum[22:0];
        ovrf_d = 1'b0;
        udrf_d = 1'b0;
        zer_d  = 1'b0;
        inf_d  = 1'b0;
        nan_d  = 1'b0;
        if (s2_nan) begin
            z_d.bits = canon_nan;
            nan_d    = 1'b1;
        end else if (s2_inf) begin
            z_d.bits = {s2_sign, 8'hff, 23'b0};
            inf_d    = 1'b1;
        end else if (s2_zero) begin
            z_d.bits = {s2_sign, 31'b0};
            zer_d    = 1'b1;
        end else if (exp_r >= 10'sd255) begin
            // overflow saturates to infinity in every mode
            z_d.bits = {s2_sign, 8'hff, 23'b0};
            ovrf_d   = 1'b1;
            inf_d    = 1'b1;
        end else if (exp_r <= 10'sd0) begin
            z_d.bits = {s2_sign, 31'b0};
            udrf_d   = 1'b1;
            zer_d    = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            ovrf      <= 1'b0;
            udrf      <= 1'b0;
            zer       <= 1'b0;
            inf       <= 1'b0;
            nan       <= 1'b0;
            norm_r    <= 1'b0;
        end else begin
            out_valid <= s2_valid;
            ovrf      <= ovrf_d;
            udrf      <= udrf_d;
            zer       <= zer_d;
            inf       <= inf_d;
            nan       <= nan_d;
            norm_r    <= carry;
        end
    end

    always_ff @(posedge clk) begin
        fp_z <= z_d;
    end

endmodule

`default_nettype wire

// ==== fp_mul.sv ====
`timescale 1ns/10ps
`default_nettype none

module fp_mul import fp_mul_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        in_valid,
    input  fp32_t       fp_x,
    input  fp32_t       fp_y,
    input  round_mode_e r_mode,
    output logic        out_valid,
    output fp32_t       fp_z,
    output logic        ovrf,
    output logic        udrf,
    output logic        zer,
    output logic        inf,
    output logic        nan
);

    // stage 1 to stage 2
    logic                        s1_valid;
    logic [prod_w-1:0]           frc_z_full;
    logic                        sign_z;
    logic signed [exp_sum_w-1:0] exp_sum;
    logic                        zero_in, inf_in, nan_in;
    round_mode_e                 s1_mode;

    // stage 2 to stage 3
    logic                        s2_valid;
    logic [norm_w-1:0]           frc_z_norm;
    logic                        norm_n;
    logic                        s2_sign;
    logic signed [exp_sum_w-1:0] s2_exp;
    logic                        s2_zero, s2_inf, s2_nan;
    round_mode_e                 s2_mode;

    // rounding carry, watched from outside
    logic                        norm_r;

    fp_mul_booth i_booth (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .fp_x       (fp_x),
        .fp_y       (fp_y),
        .r_mode     (r_mode),
        .s1_valid   (s1_valid),
        .frc_z_full (frc_z_full),
        .sign_z     (sign_z),
        .exp_sum    (exp_sum),
        .zero_in    (zero_in),
        .inf_in     (inf_in),
        .nan_in     (nan_in),
        .s1_mode    (s1_mode)
    );

    fp_mul_norm i_norm (
        .clk        (clk),
        .reset      (reset),
        .s1_valid   (s1_valid),
        .frc_z_full (frc_z_full),
        .sign_z     (sign_z),
        .exp_sum    (exp_sum),
        .zero_in    (zero_in),
        .inf_in     (inf_in),
        .nan_in     (nan_in),
        .s1_mode    (s1_mode),
        .s2_valid   (s2_valid),
        .frc_z_norm (frc_z_norm),
        .norm_n     (norm_n),
        .s2_sign    (s2_sign),
        .s2_exp     (s2_exp),
        .s2_zero    (s2_zero),
        .s2_inf     (s2_inf),
        .s2_nan     (s2_nan),
        .s2_mode    (s2_mode)
    );

    fp_mul_round i_round (
        .clk        (clk),
        .reset      (reset),
        .s2_valid   (s2_valid),
        .frc_z_norm (frc_z_norm),
        .s2_sign    (s2_sign),
        .s2_exp     (s2_exp),
        .s2_zero    (s2_zero),
        .s2_inf     (s2_inf),
        .s2_nan     (s2_nan),
        .s2_mode    (s2_mode),
        .out_valid  (out_valid),
        .fp_z       (fp_z),
        .norm_r     (norm_r),
        .ovrf       (ovrf),
        .udrf       (udrf),
        .zer        (zer),
        .inf        (inf),
        .nan        (nan)
    );

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
    output logic clk
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

endmodule

`default_nettype wire

// ==== fp_mul_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module fp_mul_checker import fp_mul_pkg::*; (
    input  logic              clk,
    input  logic              in_valid,
    input  fp32_t             fp_x,
    input  fp32_t             fp_y,
    input  logic              s1_valid,
    input  logic [prod_w-1:0] frc_z_full,
    input  logic              sign_z,
    input  logic              s2_valid,
    input  logic [norm_w-1:0] frc_z_norm,
    input  logic              norm_n,
    input  logic              s2_zero,
    input  logic              s2_inf,
    input  logic              s2_nan,
    input  logic              out_valid,
    input  fp32_t             fp_z,
    input  logic              norm_r,
    input  logic [4:0]        flags,
    output int                errors
);

    int          count = 0;
    // stage inputs as seen one cycle earlier
    logic        in_valid_q = 1'b0;
    logic [23:0] mant_x_q;
    logic [23:0] mant_y_q;
    logic        sign_q;
    logic        s1_valid_q = 1'b0;
    logic        msb_q;
    logic        s2_valid_q = 1'b0;
    logic [22:0] mant_q;

    assign errors = count;

    task automatic report(input string what);
        count++;
        $display("FAIL %0d ns: checker %s", $time, what);
    endtask

    // stage registers are all settled at negedge
    always @(negedge clk) begin
        if (s1_valid && in_valid_q) begin
            if (frc_z_full != 48'(mant_x_q) * 48'(mant_y_q)) begin
                report($sformatf("product %h for mantissas %h and %h",
                                 frc_z_full, mant_x_q, mant_y_q));
            end
            if (sign_z != sign_q) begin
                report("product sign differs from the xor of the operand signs");
            end
        end
        if (s2_valid && s1_valid_q && norm_n != msb_q) begin
            report($sformatf("norm_n %b but product msb was %b", norm_n, msb_q));
        end
        if (s2_valid && !(s2_zero || s2_inf || s2_nan) && !frc_z_norm[norm_w-1]) begin
            report($sformatf("normalized fraction %h has a clear msb", frc_z_norm));
        end
        // a rounding carry comes only from an all ones fraction and leaves zeros
        if (out_valid && s2_valid_q && flags == 5'b0
                && norm_r != (mant_q == '1 && fp_z.f.frac == 23'b0)) begin
            report($sformatf("norm_r %b for fraction %h rounded to %h",
                             norm_r, mant_q, fp_z.f.frac));
        end
        in_valid_q <= in_valid;
        mant_x_q   <= {1'b1, fp_x.f.frac};
        mant_y_q   <= {1'b1, fp_y.f.frac};
        sign_q     <= fp_x.f.sign ^ fp_y.f.sign;
        s1_valid_q <= s1_valid;
        msb_q      <= frc_z_full[prod_w-1];
        s2_valid_q <= s2_valid;
        mant_q     <= frc_z_norm[25:3];
    end

endmodule

`default_nettype wire

// ==== tb_fp_mul.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_fp_mul import fp_mul_pkg::*; ();

    // exact, rounding, special, range, burst
    localparam int n_ops      = 3 + 6 * 7 + 10 + 8 + 20;
    // five cycles allowed per operation
    localparam int timeout_ns = (n_ops * 5 + 20) * 100;

    logic        clk;
    logic        reset;
    logic        in_valid;
    fp32_t       fp_x;
    fp32_t       fp_y;
    round_mode_e r_mode;
    logic        out_valid;
    fp32_t       fp_z;
    logic        ovrf;
    logic        udrf;
    logic        zer;
    logic        inf;
    logic        nan;
    int          err_count = 0;
    int          chk_errors;

    tb_clock_gen i_clock_gen (
        .clk (clk)
    );

    fp_mul i_fp_mul (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .fp_x      (fp_x),
        .fp_y      (fp_y),
        .r_mode    (r_mode),
        .out_valid (out_valid),
        .fp_z      (fp_z),
        .ovrf      (ovrf),
        .udrf      (udrf),
        .zer       (zer),
        .inf       (inf),
        .nan       (nan)
    );

    fp_mul_checker i_checker (
        .clk        (clk),
        .in_valid   (in_valid),
        .fp_x       (fp_x),
        .fp_y       (fp_y),
        .s1_valid   (i_fp_mul.s1_valid),
        .frc_z_full (i_fp_mul.frc_z_full),
        .sign_z     (i_fp_mul.sign_z),
        .s2_valid   (i_fp_mul.s2_valid),
        .frc_z_norm (i_fp_mul.frc_z_norm),
        .norm_n     (i_fp_mul.norm_n),
        .s2_zero    (i_fp_mul.s2_zero),
        .s2_inf     (i_fp_mul.s2_inf),
        .s2_nan     (i_fp_mul.s2_nan),
        .out_valid  (out_valid),
        .fp_z       (fp_z),
        .norm_r     (i_fp_mul.norm_r),
        .flags      ({ovrf, udrf, zer, inf, nan}),
        .errors     (chk_errors)
    );

    // flags are packed as {ovrf, udrf, zer, inf, nan}
    function automatic fp32_t ref_mul(input fp32_t x, input fp32_t y,
                                      input round_mode_e m, output logic [4:0] flags);
        logic        xz;
        logic        xi;
        logic        xn;
        logic        yz;
        logic        yi;
        logic        yn;
        logic        sgn;
        logic        g;
        logic        st;
        logic        up;
        logic [47:0] p;
        logic [26:0] n;
        logic [23:0] sum;
        int          e;
        fp32_t       z;
        xz  = (x.f.exp == 8'h00);
        xi  = (x.f.exp == 8'hff) && (x.f.frac == 23'b0);
        xn  = (x.f.exp == 8'hff) && (x.f.frac != 23'b0);
        yz  = (y.f.exp == 8'h00);
        yi  = (y.f.exp == 8'hff) && (y.f.frac == 23'b0);
        yn  = (y.f.exp == 8'hff) && (y.f.frac != 23'b0);
        sgn = x.f.sign ^ y.f.sign;
        p   = {24'b0, 1'b1, x.f.frac} * {24'b0, 1'b1, y.f.frac};
        e   = int'(x.f.exp) + int'(y.f.exp) - 127;
        if (p[47]) begin
            n = {p[47:22], |p[21:0]};
            e = e + 1;
        end else begin
            n = {p[46:21], |p[20:0]};
        end
        g  = n[2];
        st = |n[1:0];
        case (m)
            rnd_ne:  up = g & (st | n[3]);
            rnd_dn:  up = sgn & (g | st);
            rnd_up:  up = !sgn & (g | st);
            rnd_mm:  up = g;
            default: up = 1'b0;
        endcase
        sum = {1'b0, n[25:3]} + {23'b0, up};
        if (sum[23]) begin
            e = e + 1;
        end
        flags  = 5'b0;
        z.bits = {sgn, 8'(e), sum[22:0]};
        if (xn || yn || (xz && yi) || (yz && xi)) begin
            z.bits = canon_nan;
            flags  = 5'b00001;
        end else if (xi || yi) begin
            z.bits = {sgn, 8'hff, 23'b0};
            flags  = 5'b00010;
        end else if (xz || yz) begin
            z.bits = {sgn, 31'b0};
            flags  = 5'b00100;
        end else if (e >= 255) begin
            z.bits = {sgn, 8'hff, 23'b0};
            flags  = 5'b10010;
        end else if (e <= 0) begin
            z.bits = {sgn, 31'b0};
            flags  = 5'b01100;
        end
        return z;
    endfunction

    function automatic fp32_t rand_normal();
        fp32_t       v;
        logic [31:0] r;
        r        = $urandom;
        v.f.sign = r[31];
        v.f.exp  = 8'(100 + r[7:0] % 55);
        v.f.frac = 23'($urandom);
        return v;
    endfunction

    task automatic compare_word(input fp32_t got, input fp32_t want, input string msg);
        if (got !== want) begin
            err_count++;
            $display("FAIL %0d ns: %s result %h expected %h", $time, msg, got, want);
        end
    endtask

    task automatic compare_flags(input logic [4:0] got, input logic [4:0] want,
                                 input string msg);
        if (got !== want) begin
            err_count++;
            $display("FAIL %0d ns: %s flags ovrf,udrf,zer,inf,nan %b expected %b",
                     $time, msg, got, want);
        end
    endtask

    task automatic check_idle(input string when);
        if (out_valid !== 1'b0) begin
            err_count++;
            $display("FAIL %0d ns: out_valid high %s", $time, when);
        end
    endtask

    task automatic check_result(input fp32_t x, input fp32_t y, input round_mode_e m,
                                input string msg);
        fp32_t      want_z;
        logic [4:0] want_f;
        want_z = ref_mul(x, y, m, want_f);
        if (out_valid !== 1'b1) begin
            err_count++;
            $display("no result came out 3 cycles after issue for %s at %0d ns", msg, $time);
        end else begin
            compare_word(fp_z, want_z, msg);
            compare_flags({ovrf, udrf, zer, inf, nan}, want_f, msg);
        end
    endtask

    // entered and left 5 ns after a rising edge
    task automatic run_single(input fp32_t x, input fp32_t y, input round_mode_e m,
                              input string msg);
        fp_x     = x;
        fp_y     = y;
        r_mode   = m;
        in_valid = 1'b1;
        @(posedge clk);
        #5;
        in_valid = 1'b0;
        repeat (2) begin
            @(posedge clk);
            #5;
        end
        check_result(x, y, m, msg);
        @(posedge clk);
        #5;
        check_idle({"one cycle after ", msg});
    endtask

    task automatic exact_test();
        run_single(32'h40400000, 32'h40400000, rnd_tz, "3.0 * 3.0");
        run_single(32'h3fc00000, 32'h40000000, rnd_tz, "1.5 * 2.0");
        run_single(32'h3fffffff, 32'h3fffffff, rnd_tz, "0x3fffffff squared");
    endtask

    task automatic rounding_test();
        fp32_t       x;
        fp32_t       y;
        round_mode_e m;
        for (int mi = 0; mi < 6; mi++) begin
            // code 7 is no defined mode
            m = (mi == 5) ? round_mode_e'(3'd7) : round_mode_e'(3'(mi));
            for (int k = 0; k < 4; k++) begin
                x        = rand_normal();
                y        = rand_normal();
                x.f.sign = k[0];
                y.f.sign = k[1];
                run_single(x, y, m, $sformatf("mode %0d random pair %0d", m, k));
            end
            // ties with odd and even lsb
            run_single(32'h3f800001, 32'hbfc00000, m, $sformatf("mode %0d odd tie", m));
            run_single(32'h3f800003, 32'h3fc00000, m, $sformatf("mode %0d even tie", m));
            // all ones fraction with guard and sticky set
            run_single(32'h3f800001, 32'h3ffffffe, m, $sformatf("mode %0d carry", m));
        end
    endtask

    task automatic special_test();
        run_single(32'h00000000, 32'h40200000, rnd_ne, "zero * 2.5");
        run_single(32'h80000000, 32'h40400000, rnd_ne, "-zero * 3.0");
        run_single(32'h00400000, 32'hc0000000, rnd_ne, "subnormal * -2.0");
        run_single(32'h7f800000, 32'hbfc00000, rnd_ne, "inf * -1.5");
        run_single(32'h40000000, 32'hff800000, rnd_ne, "2.0 * -inf");
        run_single(32'h7fc00001, 32'h3f800000, rnd_ne, "nan * 1.0");
        run_single(32'h3f800000, 32'hff800001, rnd_ne, "1.0 * nan");
        run_single(32'h00000000, 32'h7f800000, rnd_ne, "zero * inf");
        run_single(32'hff800000, 32'h80000000, rnd_ne, "-inf * -zero");
        run_single(32'h7f800000, 32'h7f800000, rnd_ne, "inf * inf");
    endtask

    task automatic range_test();
        run_single(32'h7f000000, 32'h7f000000, rnd_tz, "large squared");
        run_single(32'hff000000, 32'h40000000, rnd_dn, "exponent sum of 255");
        run_single(32'h7f7fffff, 32'h3f800001, rnd_up, "max finite rounded up");
        run_single(32'h7f7fffff, 32'h3f800000, rnd_up, "max finite * 1.0");
        run_single(32'h00800000, 32'h00800000, rnd_ne, "min normal squared");
        run_single(32'h9f800000, 32'h1f800000, rnd_ne, "tiny negative product");
        run_single(32'h20000000, 32'h1f800000, rnd_ne, "exponent sum of 0");
        run_single(32'h20000000, 32'h20000000, rnd_ne, "exponent sum of 1");
    endtask

    task automatic burst_test();
        fp32_t       bx[20];
        fp32_t       by[20];
        round_mode_e bm[20];
        for (int i = 0; i < 20; i++) begin
            bx[i] = rand_normal();
            by[i] = rand_normal();
            bm[i] = round_mode_e'(3'($urandom % 5));
        end
        for (int c = 0; c < 24; c++) begin
            if (c >= 3 && c < 23) begin
                check_result(bx[c-3], by[c-3], bm[c-3], $sformatf("burst op %0d", c - 3));
            end else begin
                check_idle($sformatf("outside the burst, cycle %0d", c));
            end
            if (c < 20) begin
                fp_x     = bx[c];
                fp_y     = by[c];
                r_mode   = bm[c];
                in_valid = 1'b1;
            end else begin
                in_valid = 1'b0;
            end
            @(posedge clk);
            #5;
        end
    endtask

    initial begin
        void'($urandom(87));
        reset    = 1'b1;
        in_valid = 1'b0;
        fp_x     = '0;
        fp_y     = '0;
        r_mode   = rnd_ne;
        repeat (8) @(posedge clk);
        #5;
        reset = 1'b0;
        check_idle("after reset");
        compare_flags({ovrf, udrf, zer, inf, nan}, 5'b0, "after reset");
        exact_test();
        rounding_test();
        special_test();
        range_test();
        burst_test();
        $display("errors: dut %0d, checker %0d", err_count, chk_errors);
        if (err_count == 0 && chk_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(timeout_ns);
        $display("timeout, the tests did not finish within %0d ns", timeout_ns);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
fp_mul_pkg.sv
fp_mul_booth.sv
fp_mul_norm.sv
fp_mul_round.sv
fp_mul.sv
tb_clock_gen.sv
fp_mul_checker.sv
tb_fp_mul.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --timescale 1ns/10ps --top-module tb_fp_mul \
    -f sources.f -o tb_fp_mul_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_fp_mul_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: FAIL" "$log"; then
    exit 1
fi
if ! grep -q "Simulation finished: PASS" "$log"; then
    echo "no pass message found in $log"
    exit 1
fi
exit 0
